//--- common/ctrlPkg.sv
package ctrlPkg;

  typedef enum logic [4:0] {
    stReset,
    stFetchRead,
    stFetchPc,
    stFetchIr,
    stDecode,
    stAluReg,
    stAluImm,
    stLui,
    stMoveHiLo,
    stJr,
    stJump,
    stStore,
    stMulDivStart,
    stMulDivWait,
    stHiLoWrite,
    stBranchCmp,
    stBranch,
    stException
  } stateT;

  // ALU select codes as seen by the datapath
  typedef enum logic [2:0] {
    aluPass = 3'b000,
    aluAdd  = 3'b001,
    aluSub  = 3'b010,
    aluAnd  = 3'b011,
    aluSlt  = 3'b111
  } aluOpT;

  typedef enum logic {srcAPc, srcAReg} srcAT;

  typedef enum logic [1:0] {srcBReg, srcBFour, srcBImm, srcBOffset} srcBT;

  typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstT;

  typedef enum logic [2:0] {wbAlu, wbHi, wbLo, wbLui, wbSlt, wbPc} memToRegT;

  typedef enum logic {addrPc, addrAlu} iorDT;

  typedef enum logic [1:0] {pcAluResult, pcJumpTarget, pcExceptVector} pcSourceT;

  typedef enum logic [1:0] {brEq, brNe, brLe, brGt} branchCondT;

  typedef enum logic [1:0] {excNone, excOpcode, excOverflow, excDivZero} causeT;

  // Memory reads per fetch
  localparam int FetchReadCycles = 2;

  // Multiplier and divider latency
  localparam int MulDivWaitCycles = 33;

  localparam int CountWidth = 6;

endpackage

//--- common/isaPkg.sv
package isaPkg;

  localparam int OpcodeWidth = 6;
  localparam int FunctWidth = 6;

  // Opcodes
  localparam logic [OpcodeWidth-1:0] OpcR     = 6'b000000;
  localparam logic [OpcodeWidth-1:0] OpcJ     = 6'b000010;
  localparam logic [OpcodeWidth-1:0] OpcJal   = 6'b000011;
  localparam logic [OpcodeWidth-1:0] OpcBeq   = 6'b000100;
  localparam logic [OpcodeWidth-1:0] OpcBne   = 6'b000101;
  localparam logic [OpcodeWidth-1:0] OpcBle   = 6'b000110;
  localparam logic [OpcodeWidth-1:0] OpcBgt   = 6'b000111;
  localparam logic [OpcodeWidth-1:0] OpcAddi  = 6'b001000;
  localparam logic [OpcodeWidth-1:0] OpcAddiu = 6'b001001;
  localparam logic [OpcodeWidth-1:0] OpcSlti  = 6'b001010;
  localparam logic [OpcodeWidth-1:0] OpcLui   = 6'b001111;
  localparam logic [OpcodeWidth-1:0] OpcSw    = 6'b101011;

  // R-type funct field
  localparam logic [FunctWidth-1:0] FnJr   = 6'b001000;
  localparam logic [FunctWidth-1:0] FnMfhi = 6'b010000;
  localparam logic [FunctWidth-1:0] FnMflo = 6'b010010;
  localparam logic [FunctWidth-1:0] FnMult = 6'b011000;
  localparam logic [FunctWidth-1:0] FnDiv  = 6'b011010;
  localparam logic [FunctWidth-1:0] FnAdd  = 6'b100000;
  localparam logic [FunctWidth-1:0] FnSub  = 6'b100010;
  localparam logic [FunctWidth-1:0] FnAnd  = 6'b100100;
  localparam logic [FunctWidth-1:0] FnSlt  = 6'b101010;

  typedef enum logic [4:0] {
    opAdd,
    opAnd,
    opSub,
    opSlt,
    opAddi,
    opAddiu,
    opSlti,
    opLui,
    opMfhi,
    opMflo,
    opJr,
    opJ,
    opJal,
    opSw,
    opMult,
    opDiv,
    opBeq,
    opBne,
    opBle,
    opBgt,
    opInvalid
  } opT;

endpackage

//--- controlSequencer/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer (
  input  logic           clk,
  input  logic           reset,
  input  isaPkg::opT     op,
  input  logic           overflow,
  input  logic           divZero,
  output ctrlPkg::stateT state,
  output isaPkg::opT     heldOp,
  output ctrlPkg::causeT cause
);

  localparam logic [ctrlPkg::CountWidth-1:0] ReadLast =
    (ctrlPkg::CountWidth)'(ctrlPkg::FetchReadCycles - 1);
  localparam logic [ctrlPkg::CountWidth-1:0] WaitLast =
    (ctrlPkg::CountWidth)'(ctrlPkg::MulDivWaitCycles - 1);

  ctrlPkg::stateT stateNext;
  ctrlPkg::causeT causeNext;
  logic [ctrlPkg::CountWidth-1:0] count;
  logic [ctrlPkg::CountWidth-1:0] countNext;

  // Execute class of a decoded operation
  function automatic ctrlPkg::stateT execState(input isaPkg::opT decoded);
    case (decoded)
      isaPkg::opAdd, isaPkg::opAnd, isaPkg::opSub, isaPkg::opSlt:
        execState = ctrlPkg::stAluReg;
      isaPkg::opAddi, isaPkg::opAddiu, isaPkg::opSlti:
        execState = ctrlPkg::stAluImm;
      isaPkg::opLui:
        execState = ctrlPkg::stLui;
      isaPkg::opMfhi, isaPkg::opMflo:
        execState = ctrlPkg::stMoveHiLo;
      isaPkg::opJr:
        execState = ctrlPkg::stJr;
      isaPkg::opJ, isaPkg::opJal:
        execState = ctrlPkg::stJump;
      isaPkg::opSw:
        execState = ctrlPkg::stStore;
      isaPkg::opMult, isaPkg::opDiv:
        execState = ctrlPkg::stMulDivStart;
      isaPkg::opBeq, isaPkg::opBne, isaPkg::opBle, isaPkg::opBgt:
        execState = ctrlPkg::stBranchCmp;
      default:
        execState = ctrlPkg::stException;
    endcase
  endfunction

  always_comb begin
    stateNext = ctrlPkg::stFetchRead;
    causeNext = ctrlPkg::excNone;
    countNext = '0;
    case (state)
      ctrlPkg::stFetchRead: begin
        if (count == ReadLast) begin
          stateNext = ctrlPkg::stFetchPc;
        end else begin
          stateNext = ctrlPkg::stFetchRead;
          countNext = count + 1'b1;
        end
      end
      ctrlPkg::stFetchPc: stateNext = ctrlPkg::stFetchIr;
      ctrlPkg::stFetchIr: stateNext = ctrlPkg::stDecode;
      ctrlPkg::stDecode: begin
        // heldOp is loaded on this edge, so dispatch on the live op
        stateNext = execState(op);
        if (op == isaPkg::opInvalid) begin
          causeNext = ctrlPkg::excOpcode;
        end
      end
      ctrlPkg::stAluReg: begin
        if (overflow && (heldOp == isaPkg::opAdd || heldOp == isaPkg::opSub)) begin
          stateNext = ctrlPkg::stException;
          causeNext = ctrlPkg::excOverflow;
        end
      end
      ctrlPkg::stAluImm: begin
        if (overflow && heldOp == isaPkg::opAddi) begin
          stateNext = ctrlPkg::stException;
          causeNext = ctrlPkg::excOverflow;
        end
      end
      ctrlPkg::stMulDivStart: begin
        if (divZero && heldOp == isaPkg::opDiv) begin
          stateNext = ctrlPkg::stException;
          causeNext = ctrlPkg::excDivZero;
        end else begin
          stateNext = ctrlPkg::stMulDivWait;
        end
      end
      ctrlPkg::stMulDivWait: begin
        if (count == WaitLast) begin
          stateNext = ctrlPkg::stHiLoWrite;
        end else begin
          stateNext = ctrlPkg::stMulDivWait;
          countNext = count + 1'b1;
        end
      end
      ctrlPkg::stBranchCmp: stateNext = ctrlPkg::stBranch;
      default: stateNext = ctrlPkg::stFetchRead;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ctrlPkg::stReset;
      count <= '0;
      cause <= ctrlPkg::excNone;
    end else begin
      state <= stateNext;
      count <= countNext;
      cause <= causeNext;
    end
  end

  always_ff @(posedge clk) begin
    if (state == ctrlPkg::stDecode) begin
      heldOp <= op;
    end
  end

endmodule

//--- hdl/controlEncoder.sv
`timescale 1ns/1ps

module controlEncoder (
  input  ctrlPkg::stateT      state,
  input  isaPkg::opT          heldOp,
  input  ctrlPkg::causeT      cause,
  output logic                pcWrite,
  output logic                pcWriteCond,
  output logic                aWrite,
  output logic                bWrite,
  output logic                epcWrite,
  output logic                hiWrite,
  output logic                loWrite,
  output logic                flagRegWrite,
  output logic                irWrite,
  output logic                regWrite,
  output logic                memWrite,
  output logic                multStart,
  output logic                divStart,
  output logic                resetOut,
  output ctrlPkg::aluOpT      aluOp,
  output ctrlPkg::srcAT       srcA,
  output ctrlPkg::srcBT       srcB,
  output ctrlPkg::regDstT     regDst,
  output ctrlPkg::memToRegT   memToReg,
  output ctrlPkg::iorDT       iorD,
  output ctrlPkg::pcSourceT   pcSource,
  output ctrlPkg::branchCondT branchCond,
  output ctrlPkg::causeT      causeOut
);

  always_comb begin
    pcWrite      = 1'b0;
    pcWriteCond  = 1'b0;
    aWrite       = 1'b0;
    bWrite       = 1'b0;
    epcWrite     = 1'b0;
    hiWrite      = 1'b0;
    loWrite      = 1'b0;
    flagRegWrite = 1'b0;
    irWrite      = 1'b0;
    regWrite     = 1'b0;
    memWrite     = 1'b0;
    multStart    = 1'b0;
    divStart     = 1'b0;
    resetOut     = 1'b0;
    aluOp        = ctrlPkg::aluPass;
    srcA         = ctrlPkg::srcAPc;
    srcB         = ctrlPkg::srcBReg;
    regDst       = ctrlPkg::dstRt;
    memToReg     = ctrlPkg::wbAlu;
    iorD         = ctrlPkg::addrPc;
    pcSource     = ctrlPkg::pcAluResult;
    branchCond   = ctrlPkg::brEq;
    causeOut     = ctrlPkg::excNone;

    case (state)
      ctrlPkg::stReset: resetOut = 1'b1;
      ctrlPkg::stFetchRead: iorD = ctrlPkg::addrPc;
      ctrlPkg::stFetchPc: begin
        // PC + 4
        pcWrite  = 1'b1;
        pcSource = ctrlPkg::pcAluResult;
        srcA     = ctrlPkg::srcAPc;
        srcB     = ctrlPkg::srcBFour;
        aluOp    = ctrlPkg::aluAdd;
      end
      ctrlPkg::stFetchIr: irWrite = 1'b1;
      ctrlPkg::stDecode: begin
        aWrite = 1'b1;
        bWrite = 1'b1;
      end
      ctrlPkg::stAluReg: begin
        regWrite = 1'b1;
        regDst   = ctrlPkg::dstRd;
        srcA     = ctrlPkg::srcAReg;
        srcB     = ctrlPkg::srcBReg;
        case (heldOp)
          isaPkg::opSub: aluOp = ctrlPkg::aluSub;
          isaPkg::opAnd: aluOp = ctrlPkg::aluAnd;
          isaPkg::opSlt: begin
            aluOp    = ctrlPkg::aluSlt;
            memToReg = ctrlPkg::wbSlt;
          end
          default: aluOp = ctrlPkg::aluAdd;
        endcase
      end
      ctrlPkg::stAluImm: begin
        regWrite = 1'b1;
        regDst   = ctrlPkg::dstRt;
        srcA     = ctrlPkg::srcAReg;
        srcB     = ctrlPkg::srcBImm;
        if (heldOp == isaPkg::opSlti) begin
          aluOp    = ctrlPkg::aluSlt;
          memToReg = ctrlPkg::wbSlt;
        end else begin
          aluOp = ctrlPkg::aluAdd;
        end
      end
      ctrlPkg::stLui: begin
        regWrite = 1'b1;
        regDst   = ctrlPkg::dstRt;
        memToReg = ctrlPkg::wbLui;
      end
      ctrlPkg::stMoveHiLo: begin
        regWrite = 1'b1;
        regDst   = ctrlPkg::dstRd;
        memToReg = (heldOp == isaPkg::opMfhi) ? ctrlPkg::wbHi : ctrlPkg::wbLo;
      end
      ctrlPkg::stJr: begin
        pcWrite  = 1'b1;
        aluOp    = ctrlPkg::aluPass;
        srcA     = ctrlPkg::srcAReg;
        pcSource = ctrlPkg::pcAluResult;
      end
      ctrlPkg::stJump: begin
        pcWrite  = 1'b1;
        pcSource = ctrlPkg::pcJumpTarget;
        if (heldOp == isaPkg::opJal) begin
          // Link address into $ra
          regWrite = 1'b1;
          regDst   = ctrlPkg::dstRa;
          memToReg = ctrlPkg::wbPc;
        end
      end
      ctrlPkg::stStore: begin
        memWrite = 1'b1;
        iorD     = ctrlPkg::addrAlu;
        aluOp    = ctrlPkg::aluAdd;
        srcA     = ctrlPkg::srcAReg;
        srcB     = ctrlPkg::srcBImm;
      end
      ctrlPkg::stMulDivStart: begin
        multStart = (heldOp == isaPkg::opMult);
        divStart  = (heldOp == isaPkg::opDiv);
      end
      ctrlPkg::stHiLoWrite: begin
        hiWrite = 1'b1;
        loWrite = 1'b1;
      end
      ctrlPkg::stBranchCmp: begin
        flagRegWrite = 1'b1;
        aluOp        = ctrlPkg::aluSub;
        srcA         = ctrlPkg::srcAReg;
        srcB         = ctrlPkg::srcBReg;
      end
      ctrlPkg::stBranch: begin
        // Target PC + offset is taken only if the flag test passes
        pcWriteCond = 1'b1;
        aluOp       = ctrlPkg::aluAdd;
        srcA        = ctrlPkg::srcAPc;
        srcB        = ctrlPkg::srcBOffset;
        case (heldOp)
          isaPkg::opBne: branchCond = ctrlPkg::brNe;
          isaPkg::opBle: branchCond = ctrlPkg::brLe;
          isaPkg::opBgt: branchCond = ctrlPkg::brGt;
          default:       branchCond = ctrlPkg::brEq;
        endcase
      end
      ctrlPkg::stException: begin
        epcWrite = 1'b1;
        pcWrite  = 1'b1;
        pcSource = ctrlPkg::pcExceptVector;
        causeOut = cause;
      end
      default: ;
    endcase
  end

endmodule

//--- hdl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [isaPkg::OpcodeWidth-1:0] opcode,
  input  logic [isaPkg::FunctWidth-1:0]  funct,
  input  logic                           overflow,
  input  logic                           divZero,
  output logic                           pcWrite,
  output logic                           pcWriteCond,
  output logic                           aWrite,
  output logic                           bWrite,
  output logic                           epcWrite,
  output logic                           hiWrite,
  output logic                           loWrite,
  output logic                           flagRegWrite,
  output logic                           irWrite,
  output logic                           regWrite,
  output logic                           memWrite,
  output logic                           multStart,
  output logic                           divStart,
  output logic                           resetOut,
  output ctrlPkg::aluOpT                 aluOp,
  output ctrlPkg::srcAT                  srcA,
  output ctrlPkg::srcBT                  srcB,
  output ctrlPkg::regDstT                regDst,
  output ctrlPkg::memToRegT              memToReg,
  output ctrlPkg::iorDT                  iorD,
  output ctrlPkg::pcSourceT              pcSource,
  output ctrlPkg::branchCondT            branchCond,
  output ctrlPkg::causeT                 cause
);

  isaPkg::opT     op;
  isaPkg::opT     heldOp;
  ctrlPkg::stateT state;
  ctrlPkg::causeT seqCause;

  instrDecoder u_instrDecoder (
    .opcode (opcode),
    .funct  (funct),
    .op     (op)
  );

  controlSequencer u_controlSequencer (
    .clk      (clk),
    .reset    (reset),
    .op       (op),
    .overflow (overflow),
    .divZero  (divZero),
    .state    (state),
    .heldOp   (heldOp),
    .cause    (seqCause)
  );

  controlEncoder u_controlEncoder (
    .state        (state),
    .heldOp       (heldOp),
    .cause        (seqCause),
    .pcWrite      (pcWrite),
    .pcWriteCond  (pcWriteCond),
    .aWrite       (aWrite),
    .bWrite       (bWrite),
    .epcWrite     (epcWrite),
    .hiWrite      (hiWrite),
    .loWrite      (loWrite),
    .flagRegWrite (flagRegWrite),
    .irWrite      (irWrite),
    .regWrite     (regWrite),
    .memWrite     (memWrite),
    .multStart    (multStart),
    .divStart     (divStart),
    .resetOut     (resetOut),
    .aluOp        (aluOp),
    .srcA         (srcA),
    .srcB         (srcB),
    .regDst       (regDst),
    .memToReg     (memToReg),
    .iorD         (iorD),
    .pcSource     (pcSource),
    .branchCond   (branchCond),
    .causeOut     (cause)
  );

endmodule

//--- hdl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
  input  logic [isaPkg::OpcodeWidth-1:0] opcode,
  input  logic [isaPkg::FunctWidth-1:0]  funct,
  output isaPkg::opT                     op
);

  always_comb begin
    op = isaPkg::opInvalid;
    case (opcode)
      isaPkg::OpcR: begin
        case (funct)
          isaPkg::FnAdd:  op = isaPkg::opAdd;
          isaPkg::FnAnd:  op = isaPkg::opAnd;
          isaPkg::FnSub:  op = isaPkg::opSub;
          isaPkg::FnSlt:  op = isaPkg::opSlt;
          isaPkg::FnMfhi: op = isaPkg::opMfhi;
          isaPkg::FnMflo: op = isaPkg::opMflo;
          isaPkg::FnJr:   op = isaPkg::opJr;
          isaPkg::FnMult: op = isaPkg::opMult;
          isaPkg::FnDiv:  op = isaPkg::opDiv;
          default:        op = isaPkg::opInvalid;
        endcase
      end
      isaPkg::OpcAddi:  op = isaPkg::opAddi;
      isaPkg::OpcAddiu: op = isaPkg::opAddiu;
      isaPkg::OpcSlti:  op = isaPkg::opSlti;
      isaPkg::OpcLui:   op = isaPkg::opLui;
      isaPkg::OpcSw:    op = isaPkg::opSw;
      isaPkg::OpcBeq:   op = isaPkg::opBeq;
      isaPkg::OpcBne:   op = isaPkg::opBne;
      isaPkg::OpcBle:   op = isaPkg::opBle;
      isaPkg::OpcBgt:   op = isaPkg::opBgt;
      isaPkg::OpcJ:     op = isaPkg::opJ;
      isaPkg::OpcJal:   op = isaPkg::opJal;
      // Anything else traps as an invalid opcode
      default:          op = isaPkg::opInvalid;
    endcase
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module controlUnitTb \
  -f src.f -o controlUnitSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi
./obj_dir/controlUnitSim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if grep -q "%Error" sim.log; then
  exit 1
fi
if grep -qx "All tests passed" sim.log; then
  exit 0
fi
exit 1

//--- src.f
common/isaPkg.sv
common/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/controlEncoder.sv
controlSequencer/controlSequencer.sv
hdl/controlUnit.sv
test/controlUnit_chk.sv
test/controlUnitTb.sv

//--- test/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;

  localparam int NumInstr = 22;
  localparam int TimeoutCycles =
    2 * NumInstr * (ctrlPkg::FetchReadCycles + ctrlPkg::MulDivWaitCycles + 8) + 16;

  // Strobe bits from pcWrite down to resetOut
  localparam logic [13:0] MPc     = 14'h2000;
  localparam logic [13:0] MPcCond = 14'h1000;
  localparam logic [13:0] MA      = 14'h0800;
  localparam logic [13:0] MB      = 14'h0400;
  localparam logic [13:0] MEpc    = 14'h0200;
  localparam logic [13:0] MHi     = 14'h0100;
  localparam logic [13:0] MLo     = 14'h0080;
  localparam logic [13:0] MFlag   = 14'h0040;
  localparam logic [13:0] MIr     = 14'h0020;
  localparam logic [13:0] MReg    = 14'h0010;
  localparam logic [13:0] MMem    = 14'h0008;
  localparam logic [13:0] MMult   = 14'h0004;
  localparam logic [13:0] MDiv    = 14'h0002;
  localparam logic [13:0] MRst    = 14'h0001;

  // Entries are {opcode, funct} and the last two are dropped encodings
  localparam logic [11:0] InstrTab [NumInstr] = '{
    {isaPkg::OpcR, isaPkg::FnAdd}, {isaPkg::OpcR, isaPkg::FnAnd},
    {isaPkg::OpcR, isaPkg::FnSub}, {isaPkg::OpcR, isaPkg::FnSlt},
    {isaPkg::OpcR, isaPkg::FnMfhi}, {isaPkg::OpcR, isaPkg::FnMflo},
    {isaPkg::OpcR, isaPkg::FnJr}, {isaPkg::OpcR, isaPkg::FnMult},
    {isaPkg::OpcR, isaPkg::FnDiv}, {isaPkg::OpcAddi, 6'h00},
    {isaPkg::OpcAddiu, 6'h00}, {isaPkg::OpcSlti, 6'h00},
    {isaPkg::OpcLui, 6'h00}, {isaPkg::OpcJ, 6'h00},
    {isaPkg::OpcJal, 6'h00}, {isaPkg::OpcSw, 6'h00},
    {isaPkg::OpcBeq, 6'h00}, {isaPkg::OpcBne, 6'h00},
    {isaPkg::OpcBle, 6'h00}, {isaPkg::OpcBgt, 6'h00},
    {6'h23, 6'h00}, {isaPkg::OpcR, 6'h00}
  };

  logic clk;
  logic reset;
  logic [5:0] opcode;
  logic [5:0] funct;
  logic overflow;
  logic divZero;
  logic pcWrite;
  logic pcWriteCond;
  logic aWrite;
  logic bWrite;
  logic epcWrite;
  logic hiWrite;
  logic loWrite;
  logic flagRegWrite;
  logic irWrite;
  logic regWrite;
  logic memWrite;
  logic multStart;
  logic divStart;
  logic resetOut;
  ctrlPkg::aluOpT aluOp;
  ctrlPkg::srcAT srcA;
  ctrlPkg::srcBT srcB;
  ctrlPkg::regDstT regDst;
  ctrlPkg::memToRegT memToReg;
  ctrlPkg::iorDT iorD;
  ctrlPkg::pcSourceT pcSource;
  ctrlPkg::branchCondT branchCond;
  ctrlPkg::causeT cause;
  logic [13:0] strobes;
  int errors = 0;

  assign strobes = {pcWrite, pcWriteCond, aWrite, bWrite, epcWrite, hiWrite, loWrite,
                    flagRegWrite, irWrite, regWrite, memWrite, multStart, divStart, resetOut};

  controlUnit u_controlUnit (
    .clk(clk), .reset(reset), .opcode(opcode), .funct(funct),
    .overflow(overflow), .divZero(divZero),
    .pcWrite(pcWrite), .pcWriteCond(pcWriteCond), .aWrite(aWrite), .bWrite(bWrite),
    .epcWrite(epcWrite), .hiWrite(hiWrite), .loWrite(loWrite),
    .flagRegWrite(flagRegWrite), .irWrite(irWrite), .regWrite(regWrite),
    .memWrite(memWrite), .multStart(multStart), .divStart(divStart),
    .resetOut(resetOut), .aluOp(aluOp), .srcA(srcA), .srcB(srcB), .regDst(regDst),
    .memToReg(memToReg), .iorD(iorD), .pcSource(pcSource),
    .branchCond(branchCond), .cause(cause)
  );

  bind controlUnit controlUnit_chk u_chk (
    .clk(clk), .reset(reset), .state(state), .divZero(divZero),
    .resetOut(resetOut), .pcWrite(pcWrite), .pcWriteCond(pcWriteCond),
    .irWrite(irWrite), .aWrite(aWrite), .bWrite(bWrite), .epcWrite(epcWrite),
    .flagRegWrite(flagRegWrite), .hiWrite(hiWrite), .loWrite(loWrite),
    .multStart(multStart), .divStart(divStart), .iorD(iorD),
    .pcSource(pcSource), .cause(cause)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic checkVal(input string name, input int actual, input int expected);
    assert (actual == expected) else begin
      errors++;
      $display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
    end
  endtask

  task automatic checkCycle(input logic [13:0] expStrobes, input ctrlPkg::causeT expCause);
    checkVal("strobes", int'(strobes), int'(expStrobes));
    checkVal("cause", int'(cause), int'(expCause));
  endtask

  task automatic checkException(input ctrlPkg::causeT expCause);
    checkCycle(MEpc | MPc, expCause);
    checkVal("pcSource", int'(pcSource), int'(ctrlPkg::pcExceptVector));
  endtask

  task automatic checkMulDiv(input logic isDiv, input logic dz);
    int n;
    checkCycle(isDiv ? MDiv : MMult, ctrlPkg::excNone);
    if (isDiv && dz) begin
      @(negedge clk);
      checkException(ctrlPkg::excDivZero);
    end else begin
      n = 0;
      do begin
        @(negedge clk);
        n++;
      end while (!hiWrite && n < ctrlPkg::MulDivWaitCycles + 8);
      checkVal("hiWrite delay", n, ctrlPkg::MulDivWaitCycles + 1);
      checkCycle(MHi | MLo, ctrlPkg::excNone);
    end
  endtask

  task automatic checkAluOp(input ctrlPkg::aluOpT expAlu, input logic isSlt);
    checkVal("aluOp", int'(aluOp), int'(expAlu));
    checkVal("memToReg", int'(memToReg), int'(isSlt ? ctrlPkg::wbSlt : ctrlPkg::wbAlu));
  endtask

  task automatic executeInstr(input logic [5:0] opc, input logic [5:0] fn,
                              input logic ovf, input logic dz);
    @(negedge clk);
    if (opc == isaPkg::OpcR) begin
      case (fn)
        isaPkg::FnAdd, isaPkg::FnSub, isaPkg::FnAnd, isaPkg::FnSlt: begin
          checkCycle(MReg, ctrlPkg::excNone);
          checkVal("regDst", int'(regDst), int'(ctrlPkg::dstRd));
          if (fn == isaPkg::FnSub) checkAluOp(ctrlPkg::aluSub, 1'b0);
          else if (fn == isaPkg::FnAnd) checkAluOp(ctrlPkg::aluAnd, 1'b0);
          else if (fn == isaPkg::FnSlt) checkAluOp(ctrlPkg::aluSlt, 1'b1);
          else checkAluOp(ctrlPkg::aluAdd, 1'b0);
          if (ovf && (fn == isaPkg::FnAdd || fn == isaPkg::FnSub)) begin
            @(negedge clk);
            checkException(ctrlPkg::excOverflow);
          end
        end
        isaPkg::FnMfhi, isaPkg::FnMflo: begin
          checkCycle(MReg, ctrlPkg::excNone);
          checkVal("regDst", int'(regDst), int'(ctrlPkg::dstRd));
          checkVal("memToReg", int'(memToReg),
                   int'(fn == isaPkg::FnMfhi ? ctrlPkg::wbHi : ctrlPkg::wbLo));
        end
        isaPkg::FnJr: begin
          checkCycle(MPc, ctrlPkg::excNone);
          checkVal("aluOp", int'(aluOp), int'(ctrlPkg::aluPass));
          checkVal("srcA", int'(srcA), int'(ctrlPkg::srcAReg));
          checkVal("pcSource", int'(pcSource), int'(ctrlPkg::pcAluResult));
        end
        isaPkg::FnMult: checkMulDiv(1'b0, dz);
        isaPkg::FnDiv: checkMulDiv(1'b1, dz);
        default: checkException(ctrlPkg::excOpcode);
      endcase
    end else begin
      case (opc)
        isaPkg::OpcAddi, isaPkg::OpcAddiu, isaPkg::OpcSlti: begin
          checkCycle(MReg, ctrlPkg::excNone);
          checkVal("regDst", int'(regDst), int'(ctrlPkg::dstRt));
          checkVal("srcB", int'(srcB), int'(ctrlPkg::srcBImm));
          if (opc == isaPkg::OpcSlti) checkAluOp(ctrlPkg::aluSlt, 1'b1);
          else checkAluOp(ctrlPkg::aluAdd, 1'b0);
          if (ovf && opc == isaPkg::OpcAddi) begin
            @(negedge clk);
            checkException(ctrlPkg::excOverflow);
          end
        end
        isaPkg::OpcLui: begin
          checkCycle(MReg, ctrlPkg::excNone);
          checkVal("regDst", int'(regDst), int'(ctrlPkg::dstRt));
          checkVal("memToReg", int'(memToReg), int'(ctrlPkg::wbLui));
        end
        isaPkg::OpcJ, isaPkg::OpcJal: begin
          checkCycle(opc == isaPkg::OpcJal ? (MPc | MReg) : MPc, ctrlPkg::excNone);
          checkVal("pcSource", int'(pcSource), int'(ctrlPkg::pcJumpTarget));
          if (opc == isaPkg::OpcJal) begin
            checkVal("regDst", int'(regDst), int'(ctrlPkg::dstRa));
            checkVal("memToReg", int'(memToReg), int'(ctrlPkg::wbPc));
          end
        end
        isaPkg::OpcSw: begin
          checkCycle(MMem, ctrlPkg::excNone);
          checkVal("iorD", int'(iorD), int'(ctrlPkg::addrAlu));
        end
        isaPkg::OpcBeq, isaPkg::OpcBne, isaPkg::OpcBle, isaPkg::OpcBgt: begin
          checkCycle(MFlag, ctrlPkg::excNone);
          checkVal("aluOp", int'(aluOp), int'(ctrlPkg::aluSub));
          @(negedge clk);
          checkCycle(MPcCond, ctrlPkg::excNone);
          checkVal("branchCond", int'(branchCond), int'(opc - isaPkg::OpcBeq));
        end
        default: checkException(ctrlPkg::excOpcode);
      endcase
    end
  endtask

  // Starts one cycle before fetch and ends in the last cycle of the instruction
  task automatic runInstr(input logic [5:0] opc, input logic [5:0] fn,
                          input logic ovf, input logic dz);
    int n;
    @(posedge clk);
    opcode <= opc;
    funct <= fn;
    overflow <= ovf;
    divZero <= dz;
    n = 0;
    do begin
      @(negedge clk);
      if (n < ctrlPkg::FetchReadCycles) begin
        checkCycle('0, ctrlPkg::excNone);
        checkVal("iorD", int'(iorD), int'(ctrlPkg::addrPc));
      end else if (n == ctrlPkg::FetchReadCycles) begin
        checkCycle(MPc, ctrlPkg::excNone);
        checkVal("pcSource", int'(pcSource), int'(ctrlPkg::pcAluResult));
      end else if (n == ctrlPkg::FetchReadCycles + 1) begin
        checkCycle(MIr, ctrlPkg::excNone);
      end
      n++;
    end while (!aWrite && n < ctrlPkg::FetchReadCycles + 8);
    checkVal("decode cycle", n, ctrlPkg::FetchReadCycles + 3);
    checkCycle(MA | MB, ctrlPkg::excNone);
    executeInstr(opc, fn, ovf, dz);
  endtask

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the instruction sequence never finished", cycles);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int order [NumInstr];
    logic [1:0] flags [NumInstr];
    int j;
    int tmp;
    void'($urandom(44589));
    reset = 1'b1;
    opcode = '0;
    funct = '0;
    overflow = 1'b0;
    divZero = 1'b0;
    for (int k = 0; k < NumInstr; k++) begin
      order[k] = k;
      flags[k] = 2'($urandom);
    end
    for (int i = NumInstr - 1; i > 0; i--) begin
      j = int'($urandom % (i + 1));
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 1; i <= 8; i++) begin
      @(posedge clk);
      if (i == 8) reset <= 1'b0;
      @(negedge clk);
      checkCycle(MRst, ctrlPkg::excNone);
    end
    // Second pass flips both flags so each instruction sees both values
    for (int pass = 0; pass < 2; pass++) begin
      for (int k = 0; k < NumInstr; k++) begin
        runInstr(InstrTab[order[k]][11:6], InstrTab[order[k]][5:0],
                 flags[order[k]][0] ^ pass[0], flags[order[k]][1] ^ pass[0]);
      end
    end
    $display("Error counts: mismatches=%0d timing assertions=%0d",
             errors, u_controlUnit.u_chk.failCount);
    if (errors == 0 && u_controlUnit.u_chk.failCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- test/controlUnit_chk.sv
`timescale 1ns/1ps

module controlUnit_chk (
  input logic               clk,
  input logic               reset,
  input ctrlPkg::stateT     state,
  input logic               divZero,
  input logic               resetOut,
  input logic               pcWrite,
  input logic               pcWriteCond,
  input logic               irWrite,
  input logic               aWrite,
  input logic               bWrite,
  input logic               epcWrite,
  input logic               flagRegWrite,
  input logic               hiWrite,
  input logic               loWrite,
  input logic               multStart,
  input logic               divStart,
  input ctrlPkg::iorDT      iorD,
  input ctrlPkg::pcSourceT  pcSource,
  input ctrlPkg::causeT     cause
);

  int failCount = 0;

  resetIdle: assert property (@(posedge clk)
    reset |=> resetOut && !pcWrite && !irWrite && !epcWrite && !aWrite)
    else begin
      failCount = failCount + 1;
      $error("Strobe active or resetOut low while in reset");
    end

  // Memory reads come right before the PC increment
  fetchReads: assert property (@(posedge clk) disable iff (reset)
    (state == ctrlPkg::stFetchPc) |->
      $past(state == ctrlPkg::stFetchRead && iorD == ctrlPkg::addrPc) &&
      $past(state == ctrlPkg::stFetchRead, ctrlPkg::FetchReadCycles) &&
      $past(state != ctrlPkg::stFetchRead, ctrlPkg::FetchReadCycles + 1))
    else begin
      failCount = failCount + 1;
      $error("Fetch read phase has the wrong length");
    end

  fetchOrder: assert property (@(posedge clk) disable iff (reset)
    (state == ctrlPkg::stFetchPc) |->
      pcWrite && pcSource == ctrlPkg::pcAluResult ##1 irWrite ##1 (aWrite && bWrite))
    else begin
      failCount = failCount + 1;
      $error("Fetch steps out of order");
    end

  startPulse: assert property (@(posedge clk) disable iff (reset)
    (multStart || divStart) |=> !multStart && !divStart)
    else begin
      failCount = failCount + 1;
      $error("Multiply or divide start held longer than one cycle");
    end

  mulDivLatency: assert property (@(posedge clk) disable iff (reset)
    (multStart || (divStart && !divZero)) |->
      ##(ctrlPkg::MulDivWaitCycles + 1) (hiWrite && loWrite))
    else begin
      failCount = failCount + 1;
      $error("hi/lo write not at the expected cycle after start");
    end

  exceptionCycle: assert property (@(posedge clk) disable iff (reset)
    epcWrite |-> pcWrite && pcSource == ctrlPkg::pcExceptVector &&
      cause != ctrlPkg::excNone ##1 (state == ctrlPkg::stFetchRead))
    else begin
      failCount = failCount + 1;
      $error("Exception cycle malformed or not followed by fetch");
    end

  causeIdle: assert property (@(posedge clk) disable iff (reset)
    !epcWrite |-> cause == ctrlPkg::excNone)
    else begin
      failCount = failCount + 1;
      $error("Cause reported outside the exception cycle");
    end

  branchSeq: assert property (@(posedge clk) disable iff (reset)
    flagRegWrite |=> pcWriteCond)
    else begin
      failCount = failCount + 1;
      $error("Branch compare not followed by conditional PC write");
    end

endmodule
